// File: upscaler.f
+incdir+source
source/upscaler_pkg.sv
source/upscaler_if.sv
source/line_writer.sv
source/line_store.sv
source/line_sync.sv
source/step_divider.sv
source/line_reader.sv
source/upscaler.sv
test/upscaler_chk.sv
test/upscaler_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module upscaler_tb -f upscaler.f > sim.log 2>&1 \
	&& ./obj_dir/Vupscaler_tb >> sim.log 2>&1 \
	|| echo "*** FAILED ***" >> sim.log
cat sim.log
grep -q "\*\*\* FAILED \*\*\*" sim.log && exit 1 || exit 0

// File: test/upscaler_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "upscaler_config.svh"

module upscaler_tb;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_LINES = 9;
	localparam int MAX_PIXELS = 128;
	localparam int CD = `COMPONENT_DEPTH;
	// upper bound on one input line, its gap and one output line
	localparam int LINE_CYCLES = 400;

	logic rst;
	logic pixel_clk_a;
	logic hsync_a;
	logic hblank_a;
	logic [CD-1:0] red_a;
	logic [CD-1:0] green_a;
	logic [CD-1:0] blue_a;
	logic pixel_clk_b;
	logic hsync_b;
	logic hblank_b;
	wire [CD-1:0] red_b;
	wire [CD-1:0] green_b;
	wire [CD-1:0] blue_b;

	// stored colours, one row per input line
	upscaler_pkg::rgb_t pattern [NUM_LINES][MAX_PIXELS];

	// zero input width means no input line before that output line
	int in_width [NUM_LINES] = '{0, 0, 64, 64, 64, 96, 96, 40, 40};
	int out_width [NUM_LINES] = '{128, 128, 128, 96, 96, 48, 48, 64, 64};

	// source line and widths of the output line on screen
	int cur_src;
	int cur_win;
	int cur_wout;

	upscaler_pkg::rgb_t exp_d0;
	upscaler_pkg::rgb_t exp_d1;
	upscaler_pkg::rgb_t exp_d2;
	int primed;
	int k;
	int checks;
	int errors;
	int seed;

	upscaler UUT (
		.rst(rst),
		.pixel_clk_a(pixel_clk_a),
		.hsync_a(hsync_a),
		.hblank_a(hblank_a),
		.red_a(red_a),
		.green_a(green_a),
		.blue_a(blue_a),
		.pixel_clk_b(pixel_clk_b),
		.hsync_b(hsync_b),
		.hblank_b(hblank_b),
		.red_b(red_b),
		.green_b(green_b),
		.blue_b(blue_b)
	);

	initial begin
		pixel_clk_a = 1'b0;
		forever #(CLK_PERIOD / 2) pixel_clk_a = ~pixel_clk_a;
	end

	// output clock runs 7 ns behind the input clock
	initial begin
		pixel_clk_b = 1'b0;
		#7;
		forever #(CLK_PERIOD / 2) pixel_clk_b = ~pixel_clk_b;
	end

	// output pixel k of a line, from the scaling rule
	function automatic upscaler_pkg::rgb_t expected_pixel(int src, int w_in, int w_out, int idx);
		int step;
		int pos;
		upscaler_pkg::rgb_t px;
		px = '0;
		if (w_in != 0 && w_out != 0) begin
			step = (w_in * (1 << `DELTA_WIDTH)) / w_out;
			pos = (idx * step) / (1 << `DELTA_WIDTH);
			if (pos > w_in - 1) begin
				pos = w_in - 1;
			end
			px = pattern[src][pos];
		end
		return px;
	endfunction

	task automatic next_edge_a();
		@(posedge pixel_clk_a);
		#2;
	endtask

	task automatic next_edge_b();
		@(posedge pixel_clk_b);
		#2;
	endtask

	task automatic send_input_line(input int src, input int width);
		repeat (4) begin
			next_edge_a();
			hblank_a = 1'b1;
			hsync_a = 1'b0;
		end
		for (int p = 0; p < width; p++) begin
			next_edge_a();
			hblank_a = 1'b0;
			red_a = pattern[src][p].red;
			green_a = pattern[src][p].green;
			blue_a = pattern[src][p].blue;
		end
		next_edge_a();
		hblank_a = 1'b1;
		repeat (3) next_edge_a();
		repeat (4) begin
			next_edge_a();
			hsync_a = 1'b1;
		end
		next_edge_a();
		hsync_a = 1'b0;
		// let the line cross into the output domain
		repeat (32) next_edge_a();
	endtask

	task automatic show_output_line(input int width);
		repeat (4) begin
			next_edge_b();
			hsync_b = 1'b1;
			hblank_b = 1'b1;
		end
		next_edge_b();
		hsync_b = 1'b0;
		// divider needs up to 21 cycles before active starts
		repeat (29) next_edge_b();
		repeat (width) begin
			next_edge_b();
			hblank_b = 1'b0;
		end
		next_edge_b();
		hblank_b = 1'b1;
		repeat (7) next_edge_b();
	endtask

	// expected colour for each sample, two cycles ahead of the output
	always @(posedge pixel_clk_b) begin
		exp_d2 = exp_d1;
		exp_d1 = exp_d0;
		if (rst || hblank_b) begin
			exp_d0 = '0;
		end else begin
			exp_d0 = expected_pixel(cur_src, cur_win, cur_wout, k);
			k++;
		end
		if (hsync_b) begin
			k = 0;
		end
		if (primed < 3) begin
			primed++;
		end
	end

	always @(negedge pixel_clk_b) begin
		if (primed >= 3) begin
			checks++;
			if (red_b !== exp_d2.red) begin
				errors++;
				$display("ERROR %0t red_b expected %h actual %h", $time, exp_d2.red, red_b);
			end
			if (green_b !== exp_d2.green) begin
				errors++;
				$display("ERROR %0t green_b expected %h actual %h", $time, exp_d2.green, green_b);
			end
			if (blue_b !== exp_d2.blue) begin
				errors++;
				$display("ERROR %0t blue_b expected %h actual %h", $time, exp_d2.blue, blue_b);
			end
		end
	end

	initial begin
		#((RESET_CYCLES + NUM_LINES * LINE_CYCLES + 200) * CLK_PERIOD);
		$display("timeout, the line sequence did not finish in the expected time");
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		int next_src;
		int newest_src;
		int newest_win;
		int prev_wout;
		rst = 1'b1;
		hsync_a = 1'b0;
		hblank_a = 1'b1;
		red_a = '0;
		green_a = '0;
		blue_a = '0;
		hsync_b = 1'b0;
		hblank_b = 1'b1;
		cur_src = 0;
		cur_win = 0;
		cur_wout = 0;
		exp_d0 = '0;
		exp_d1 = '0;
		exp_d2 = '0;
		primed = 0;
		k = 0;
		checks = 0;
		errors = 0;
		next_src = 0;
		newest_src = 0;
		newest_win = 0;
		prev_wout = 0;
		seed = 15920;
		// red is the line, green the pixel index, blue is random
		for (int l = 0; l < NUM_LINES; l++) begin
			for (int p = 0; p < MAX_PIXELS; p++) begin
				pattern[l][p] = {CD'(l), CD'(p), CD'($random(seed))};
			end
		end
		repeat (RESET_CYCLES) @(posedge pixel_clk_a);
		#2;
		rst = 1'b0;
		for (int i = 0; i < NUM_LINES; i++) begin
			if (in_width[i] != 0) begin
				send_input_line(next_src, in_width[i]);
				newest_src = next_src;
				newest_win = in_width[i];
				next_src++;
			end
			// step uses the width of the output line before this one
			cur_src = newest_src;
			cur_win = newest_win;
			cur_wout = prev_wout;
			show_output_line(out_width[i]);
			prev_wout = out_width[i];
		end
		repeat (4) next_edge_b();
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: test/upscaler_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "upscaler_config.svh"

module upscaler_chk (
	input wire pixel_clk_a,
	input wire pixel_clk_b,
	input wire rst,
	input wire hblank_a,
	input wire hblank_b,
	input wire [`COMPONENT_DEPTH-1:0] red_b,
	input wire [`COMPONENT_DEPTH-1:0] green_b,
	input wire [`COMPONENT_DEPTH-1:0] blue_b,
	input wire wr_en,
	input wire line_ready,
	input wire div_start,
	input wire div_done
);

	// longest divide, start to done
	localparam int DIV_LIMIT = `POS_WIDTH + `DELTA_WIDTH + 2;

	logic div_waiting;
	logic [5:0] div_cycles;

	// cycles since the last divider start
	always_ff @(posedge pixel_clk_b) begin
		if (rst) begin
			div_waiting <= 1'b0;
			div_cycles <= '0;
		end else if (div_start) begin
			div_waiting <= 1'b1;
			div_cycles <= 6'd1;
		end else if (div_waiting) begin
			if (div_done) begin
				div_waiting <= 1'b0;
			end else begin
				div_cycles <= div_cycles + 1'b1;
			end
		end
	end

	// output is registered twice after the blanking sample
	assert property (@(posedge pixel_clk_b) disable iff (rst)
		$past(hblank_b, 3) |-> (red_b == '0 && green_b == '0 && blue_b == '0))
		else $error("colour output not zero after a blanking cycle");

	assert property (@(posedge pixel_clk_a) disable iff (rst)
		wr_en |-> !$past(hblank_a))
		else $error("line write during input blanking");

	assert property (@(posedge pixel_clk_b) disable iff (rst)
		(div_waiting && div_cycles >= DIV_LIMIT) |-> div_done)
		else $error("divider did not finish in time");

	assert property (@(posedge pixel_clk_b) disable iff (rst)
		line_ready |-> !$past(line_ready))
		else $error("line_ready wider than one cycle");

endmodule

bind upscaler upscaler_chk u_chk (
	.pixel_clk_a(pixel_clk_a),
	.pixel_clk_b(pixel_clk_b),
	.rst(rst),
	.hblank_a(hblank_a),
	.hblank_b(hblank_b),
	.red_b(red_b),
	.green_b(green_b),
	.blue_b(blue_b),
	.wr_en(wr_bus.en),
	.line_ready(line_ready),
	.div_start(u_reader.u_divider.start),
	.div_done(u_reader.u_divider.done)
);

`default_nettype wire

// File: source/upscaler.sv
`timescale 1ns/1ps
`default_nettype none

`include "upscaler_config.svh"

module upscaler (
	input wire rst,

	input wire pixel_clk_a,
	input wire hsync_a,
	input wire hblank_a,
	input wire [`COMPONENT_DEPTH-1:0] red_a,
	input wire [`COMPONENT_DEPTH-1:0] green_a,
	input wire [`COMPONENT_DEPTH-1:0] blue_a,

	input wire pixel_clk_b,
	input wire hsync_b,
	input wire hblank_b,
	output wire [`COMPONENT_DEPTH-1:0] red_b,
	output wire [`COMPONENT_DEPTH-1:0] green_b,
	output wire [`COMPONENT_DEPTH-1:0] blue_b
);

	upscaler_pkg::rgb_t pixel_a;
	upscaler_pkg::rgb_t pixel_b;
	logic line_done;
	upscaler_pkg::slot_t line_done_slot;
	upscaler_pkg::pos_t line_done_width;
	logic line_ready;
	upscaler_pkg::slot_t ready_slot;
	upscaler_pkg::pos_t ready_width;

	line_write_if wr_bus ();
	line_read_if rd_bus ();

	assign pixel_a = {red_a, green_a, blue_a};

	assign red_b = pixel_b.red;
	assign green_b = pixel_b.green;
	assign blue_b = pixel_b.blue;

	// input side, domain a
	line_writer u_writer (
		.pixel_clk_a(pixel_clk_a),
		.rst(rst),
		.hsync_a(hsync_a),
		.hblank_a(hblank_a),
		.pixel_a(pixel_a),
		.wr(wr_bus.writer),
		.done(line_done),
		.done_slot(line_done_slot),
		.done_width(line_done_width)
	);

	line_store u_store (
		.pixel_clk_a(pixel_clk_a),
		.pixel_clk_b(pixel_clk_b),
		.wr(wr_bus.store),
		.rd(rd_bus.store)
	);

	// completed lines cross into domain b
	line_sync u_sync (
		.pixel_clk_a(pixel_clk_a),
		.pixel_clk_b(pixel_clk_b),
		.rst(rst),
		.done(line_done),
		.done_slot(line_done_slot),
		.done_width(line_done_width),
		.line_ready(line_ready),
		.ready_slot(ready_slot),
		.ready_width(ready_width)
	);

	// output side, domain b
	line_reader u_reader (
		.pixel_clk_b(pixel_clk_b),
		.rst(rst),
		.hsync_b(hsync_b),
		.hblank_b(hblank_b),
		.line_ready(line_ready),
		.ready_slot(ready_slot),
		.ready_width(ready_width),
		.rd(rd_bus.reader),
		.pixel_b(pixel_b)
	);

endmodule

`default_nettype wire

// File: source/line_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "upscaler_config.svh"

module line_reader (
	input wire pixel_clk_b,
	input wire rst,
	input wire hsync_b,
	input wire hblank_b,
	input wire line_ready,
	input wire upscaler_pkg::slot_t ready_slot,
	input wire upscaler_pkg::pos_t ready_width,
	line_read_if.reader rd,
	output upscaler_pkg::rgb_t pixel_b
);

	localparam int DW = `DELTA_WIDTH;
	localparam int AW = $bits(upscaler_pkg::acc_t);

	logic hsync_q;
	logic line_end;
	logic active;
	upscaler_pkg::slot_t newest_slot;
	upscaler_pkg::pos_t newest_width;
	upscaler_pkg::slot_t in_slot_now;
	upscaler_pkg::pos_t in_width_now;
	upscaler_pkg::slot_t line_slot;
	upscaler_pkg::pos_t line_width;
	upscaler_pkg::pos_t out_count;
	logic widths_ok;
	logic started;
	logic step_ok;
	upscaler_pkg::step_t step;
	upscaler_pkg::step_t div_dividend;
	upscaler_pkg::step_t div_quotient;
	logic div_done;
	upscaler_pkg::acc_t acc;
	logic [AW:0] acc_sum;
	upscaler_pkg::pos_t acc_int;
	upscaler_pkg::pos_t read_pos;
	logic act_d1;
	logic act_d2;

	assign active = ~hblank_b;
	assign line_end = hsync_q & ~hsync_b;

	// a line arriving on the same cycle already counts as newest
	assign in_slot_now = line_ready ? ready_slot : newest_slot;
	assign in_width_now = line_ready ? ready_width : newest_width;
	assign div_dividend = {in_width_now, {DW{1'b0}}};

	assign acc_sum = {1'b0, acc} + {1'b0, step};
	assign acc_int = acc[AW-1:DW];

	// hold at the last stored pixel
	assign read_pos = (acc_int >= line_width) ? line_width - 1'b1 : acc_int;

	step_divider u_divider (
		.pixel_clk_a(pixel_clk_b),
		.rst(rst),
		.start(line_end),
		.dividend(div_dividend),
		.divisor(out_count),
		.done(div_done),
		.quotient(div_quotient)
	);

	always_ff @(posedge pixel_clk_b) begin
		if (rst) begin
			hsync_q <= 1'b0;
			newest_slot <= '0;
			newest_width <= '0;
			out_count <= '0;
			widths_ok <= 1'b0;
			started <= 1'b0;
			step_ok <= 1'b0;
			acc <= '0;
			rd.en <= 1'b0;
			act_d1 <= 1'b0;
			act_d2 <= 1'b0;
			pixel_b <= '0;
		end else begin
			hsync_q <= hsync_b;
			newest_slot <= in_slot_now;
			newest_width <= in_width_now;
			if (line_end) begin
				out_count <= '0;
				widths_ok <= (in_width_now != '0) && (out_count != '0);
				started <= 1'b0;
				step_ok <= 1'b0;
				acc <= '0;
			end else begin
				if (active) begin
					started <= 1'b1;
					acc <= acc_sum[AW] ? '1 : acc_sum[AW-1:0];
					if (out_count != '1) begin
						out_count <= out_count + 1'b1;
					end
				end
				// a step that lands after active has begun is ignored
				if (div_done && !started && !active) begin
					step_ok <= widths_ok;
				end
			end
			rd.en <= active;
			act_d1 <= active & step_ok;
			act_d2 <= act_d1;
			pixel_b <= act_d2 ? rd.data : '0;
		end
	end

	always_ff @(posedge pixel_clk_b) begin
		if (line_end) begin
			line_slot <= in_slot_now;
			line_width <= in_width_now;
		end
		if (div_done && !started && !active) begin
			step <= div_quotient;
		end
		rd.slot <= line_slot;
		rd.pos <= read_pos;
	end

endmodule

`default_nettype wire

// File: source/step_divider.sv
`timescale 1ns/1ps
`default_nettype none

module step_divider (
	input wire pixel_clk_a,
	input wire rst,
	input wire start,
	input wire upscaler_pkg::step_t dividend,
	input wire upscaler_pkg::pos_t divisor,
	output logic done,
	output upscaler_pkg::step_t quotient
);

	localparam int W = $bits(upscaler_pkg::step_t);
	localparam int PW = $bits(upscaler_pkg::pos_t);
	localparam int CW = $clog2(W + 1);

	logic busy;
	logic finish;
	logic fits;
	logic tail_zero;
	logic [CW-1:0] remaining;
	upscaler_pkg::pos_t rem;
	upscaler_pkg::pos_t div_q;
	upscaler_pkg::step_t work;
	upscaler_pkg::step_t upper_mask;
	logic [PW:0] trial;

	// work holds the unused dividend bits on top and quotient bits below
	assign trial = {rem, work[W-1]};
	assign fits = trial >= {1'b0, div_q};

	// all further quotient bits are zero once nothing is left to divide
	assign upper_mask = ~(upscaler_pkg::step_t'('1) >> remaining);
	assign tail_zero = (rem == '0) && ((work & upper_mask) == '0);
	assign finish = (remaining == '0) || tail_zero;

	always_ff @(posedge pixel_clk_a) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
			remaining <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				remaining <= CW'(W);
			end else if (busy) begin
				if (finish) begin
					busy <= 1'b0;
					done <= 1'b1;
				end else begin
					remaining <= remaining - 1'b1;
				end
			end
		end
	end

	always_ff @(posedge pixel_clk_a) begin
		if (start) begin
			rem <= '0;
			div_q <= divisor;
			work <= dividend;
		end else if (busy) begin
			if (finish) begin
				// move the quotient bits up past the skipped zeros
				quotient <= work << remaining;
			end else begin
				rem <= fits ? upscaler_pkg::pos_t'(trial - {1'b0, div_q}) : trial[PW-1:0];
				work <= {work[W-2:0], fits};
			end
		end
	end

endmodule

`default_nettype wire

// File: source/line_sync.sv
`timescale 1ns/1ps
`default_nettype none

module line_sync (
	input wire pixel_clk_a,
	input wire pixel_clk_b,
	input wire rst,
	input wire done,
	input wire upscaler_pkg::slot_t done_slot,
	input wire upscaler_pkg::pos_t done_width,
	output logic line_ready,
	output upscaler_pkg::slot_t ready_slot,
	output upscaler_pkg::pos_t ready_width
);

	logic toggle_a;
	logic ack_meta_a;
	logic ack_a;
	logic busy_a;
	logic accept_a;
	upscaler_pkg::slot_t held_slot;
	upscaler_pkg::pos_t held_width;
	logic toggle_meta_b;
	logic toggle_sync_b;
	logic toggle_prev_b;
	logic edge_b;

	// a line is in flight until domain b echoes the toggle back
	assign busy_a = toggle_a ^ ack_a;
	assign accept_a = done & ~busy_a;
	assign edge_b = toggle_sync_b ^ toggle_prev_b;

	always_ff @(posedge pixel_clk_a) begin
		if (rst) begin
			toggle_a <= 1'b0;
			ack_meta_a <= 1'b0;
			ack_a <= 1'b0;
		end else begin
			ack_meta_a <= toggle_prev_b;
			ack_a <= ack_meta_a;
			if (accept_a) begin
				toggle_a <= ~toggle_a;
			end
		end
	end

	// slot and width stay stable while the toggle crosses
	always_ff @(posedge pixel_clk_a) begin
		if (accept_a) begin
			held_slot <= done_slot;
			held_width <= done_width;
		end
	end

	always_ff @(posedge pixel_clk_b) begin
		if (rst) begin
			toggle_meta_b <= 1'b0;
			toggle_sync_b <= 1'b0;
			toggle_prev_b <= 1'b0;
			line_ready <= 1'b0;
		end else begin
			toggle_meta_b <= toggle_a;
			toggle_sync_b <= toggle_meta_b;
			toggle_prev_b <= toggle_sync_b;
			line_ready <= edge_b;
		end
	end

	always_ff @(posedge pixel_clk_b) begin
		if (edge_b) begin
			ready_slot <= held_slot;
			ready_width <= held_width;
		end
	end

endmodule

`default_nettype wire

// File: source/line_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "upscaler_config.svh"

module line_store (
	input wire pixel_clk_a,
	input wire pixel_clk_b,
	line_write_if.store wr,
	line_read_if.store rd
);

	// address bits inside one slot
	localparam int ADDR_BITS = $clog2(`LINE_BUFFER_SIZE);

	// one row per slot, one word per pixel
	upscaler_pkg::rgb_t mem [`LINE_BUFFER_COUNT][`LINE_BUFFER_SIZE];

	// write port in the input pixel domain
	always_ff @(posedge pixel_clk_a) begin
		if (wr.en) begin
			mem[wr.slot][wr.pos[ADDR_BITS-1:0]] <= wr.data;
		end
	end

	// registered read port in the output pixel domain
	// the word holds until the next read
	always_ff @(posedge pixel_clk_b) begin
		if (rd.en) begin
			rd.data <= mem[rd.slot][rd.pos[ADDR_BITS-1:0]];
		end
	end

endmodule

`default_nettype wire

// File: source/line_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "upscaler_config.svh"

module line_writer (
	input wire pixel_clk_a,
	input wire rst,
	input wire hsync_a,
	input wire hblank_a,
	input wire upscaler_pkg::rgb_t pixel_a,
	line_write_if.writer wr,
	output logic done,
	output upscaler_pkg::slot_t done_slot,
	output upscaler_pkg::pos_t done_width
);

	logic hsync_q;
	logic line_end;
	logic active;
	logic in_range;
	upscaler_pkg::pos_t count;
	upscaler_pkg::slot_t slot;

	assign active = ~hblank_a;
	assign line_end = hsync_q & ~hsync_a;

	// pixels past the end of a slot are not stored
	assign in_range = count < upscaler_pkg::pos_t'(`LINE_BUFFER_SIZE);

	always_ff @(posedge pixel_clk_a) begin
		if (rst) begin
			hsync_q <= 1'b0;
			count <= '0;
			slot <= '0;
			wr.en <= 1'b0;
			done <= 1'b0;
		end else begin
			hsync_q <= hsync_a;
			done <= line_end;
			wr.en <= active & in_range;
			if (line_end) begin
				count <= '0;
				// step round the ring of slots
				if (slot == upscaler_pkg::slot_t'(`LINE_BUFFER_COUNT - 1)) begin
					slot <= '0;
				end else begin
					slot <= slot + 1'b1;
				end
			end else if (active && in_range) begin
				count <= count + 1'b1;
			end
		end
	end

	// write address and colour trail the sample by one cycle
	always_ff @(posedge pixel_clk_a) begin
		wr.slot <= slot;
		wr.pos <= count;
		wr.data <= pixel_a;
		if (line_end) begin
			done_slot <= slot;
			done_width <= count;
		end
	end

endmodule

`default_nettype wire

// File: source/upscaler_if.sv
`timescale 1ns/1ps
`default_nettype none

// pixel writes from the input side into the line memory
interface line_write_if;
	logic en;
	upscaler_pkg::slot_t slot;
	upscaler_pkg::pos_t pos;
	upscaler_pkg::rgb_t data;

	modport writer (
		output en,
		output slot,
		output pos,
		output data
	);

	modport store (
		input en,
		input slot,
		input pos,
		input data
	);
endinterface

// reads from the output side, data follows en by one cycle
interface line_read_if;
	logic en;
	upscaler_pkg::slot_t slot;
	upscaler_pkg::pos_t pos;
	upscaler_pkg::rgb_t data;

	modport reader (
		output en,
		output slot,
		output pos,
		input data
	);

	modport store (
		input en,
		input slot,
		input pos,
		output data
	);
endinterface

`default_nettype wire

// File: source/upscaler_pkg.sv
`default_nettype none

`include "upscaler_config.svh"

package upscaler_pkg;

	// one pixel, red in the top bits
	typedef struct packed {
		logic [`COMPONENT_DEPTH-1:0] red;
		logic [`COMPONENT_DEPTH-1:0] green;
		logic [`COMPONENT_DEPTH-1:0] blue;
	} rgb_t;

	// pixel position or active line width
	typedef logic [`POS_WIDTH-1:0] pos_t;

	// index into the ring of line slots
	typedef logic [$clog2(`LINE_BUFFER_COUNT)-1:0] slot_t;

	// fixed point step, integer part above DELTA_WIDTH fraction bits
	typedef logic [`POS_WIDTH+`DELTA_WIDTH-1:0] step_t;

	// read position accumulator in the same layout as the step
	typedef logic [`POS_WIDTH+`DELTA_WIDTH-1:0] acc_t;

endpackage

`default_nettype wire

// File: source/upscaler_config.svh
`ifndef UPSCALER_CONFIG_SVH
`define UPSCALER_CONFIG_SVH

// bits per colour component
`define COMPONENT_DEPTH 8

// pixels held by one line slot
`define LINE_BUFFER_SIZE 1024

// number of line slots in the ring
`define LINE_BUFFER_COUNT 4

// bits of a pixel position or a line width
`define POS_WIDTH 11

// fraction bits of the scaling step
`define DELTA_WIDTH 8

`endif
